/* Bender.yml */
package:
  name: line_car

sources:
  - include_dirs:
      - logic
    files:
      - logic/navPkg.sv
      - logic/panelPkg.sv
      - logic/routeIf.sv
      - logic/phaseTimers.sv
      - logic/checkpointTracker.sv
      - logic/navFsm.sv
      - logic/statusPanel.sv
      - logic/lineCar.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/lineCar_asserts.sv
      - sim/lineCar_tb.sv

/* logic/car_consts.svh */
`ifndef CAR_CONSTS_SVH
`define CAR_CONSTS_SVH

// Cycles per countdown step, four steps in COUNT
`define COUNT_STEP_TICKS 8

// Length of the STOP phase in cycles
`define STOP_HOLD_TICKS 12

// Half-period of the bar flash while reversing
`define BACK_FLASH_TICKS 4

// Cycles per position of the choose lamp
`define LAMP_TICKS 6

`endif

/* logic/checkpointTracker.sv */
`timescale 1ns/10ps
`default_nettype none

module checkpointTracker (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire navPkg::navState state,
    input  wire navPkg::navState lastState,
    input  wire navPkg::roadCode road,
    routeIf.tracker              route
);

    logic prevFull;
    logic altBit;
    logic straightNow;

    assign straightNow = navPkg::isStraight(state);

    // Each flag sets on leaving the junction pattern, clears outside its phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            route.cp1 <= 1'b0;
            route.cp2 <= 1'b0;
            route.cp3 <= 1'b0;
            route.cp4 <= 1'b0;
            route.cp5 <= 1'b0;
        end else begin
            if (state == navPkg::CHOOSE && road != navPkg::roadFull) begin
                route.cp1 <= 1'b1;
            end else if (state != navPkg::CHOOSE) begin
                route.cp1 <= 1'b0;
            end

            // Fresh from the countdown counts as clear of the start line
            if (lastState == navPkg::COUNT || (straightNow && road != navPkg::roadFull)) begin
                route.cp2 <= 1'b1;
            end else if (!straightNow) begin
                route.cp2 <= 1'b0;
            end

            if (state == navPkg::LEFT && road != navPkg::roadFull) begin
                route.cp3 <= 1'b1;
            end else if (state != navPkg::LEFT) begin
                route.cp3 <= 1'b0;
            end

            if (state == navPkg::RIGHT && road != navPkg::roadFull) begin
                route.cp4 <= 1'b1;
            end else if (state != navPkg::RIGHT) begin
                route.cp4 <= 1'b0;
            end

            if (state == navPkg::LEFT && road != navPkg::roadSplit) begin
                route.cp5 <= 1'b1;
            end else if (state != navPkg::LEFT) begin
                route.cp5 <= 1'b0;
            end
        end
    end

    // Full-line edges during a right turn, saturating at two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prevFull         <= 1'b0;
            route.rightCount <= 2'd0;
            route.doneRight  <= 1'b0;
        end else begin
            prevFull <= (state == navPkg::RIGHT) && (road == navPkg::roadFull);
            if (state != navPkg::RIGHT) begin
                route.rightCount <= 2'd0;
                route.doneRight  <= 1'b0;
            end else begin
                if (route.cp4 && road == navPkg::roadFull && !prevFull &&
                    route.rightCount != 2'd2) begin
                    route.rightCount <= route.rightCount + 2'd1;
                end
                if (route.rightCount == 2'd2) begin
                    route.doneRight <= 1'b1;
                end
            end
        end
    end

    // Route memory, altBit picks the side of the next reverse search
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            route.nextManoeuvre <= navPkg::LEFT;
            altBit              <= 1'b0;
        end else begin
            case (state)
                navPkg::STRAIGHT, navPkg::LITTLE_LEFT, navPkg::LITTLE_RIGHT: begin
                    route.nextManoeuvre <= (road == navPkg::roadNone) ?
                                           navPkg::BACK : navPkg::STRAIGHT;
                end
                navPkg::CHOOSE: begin
                    if (road == navPkg::roadSplit) begin
                        route.nextManoeuvre <= navPkg::LEFT;
                        altBit              <= 1'b0;
                    end
                end
                navPkg::LEFT: begin
                    if (road == navPkg::roadSplit) begin
                        route.nextManoeuvre <= navPkg::RIGHT;
                    end else if (road == navPkg::roadFull) begin
                        route.nextManoeuvre <= navPkg::STRAIGHT;
                    end
                end
                navPkg::RIGHT: begin
                    if (road == navPkg::roadFull) begin
                        route.nextManoeuvre <= navPkg::STRAIGHT;
                    end
                end
                navPkg::BACK: begin
                    if (road == navPkg::roadFull) begin
                        route.nextManoeuvre <= altBit ? navPkg::RIGHT : navPkg::LEFT;
                        altBit              <= ~altBit;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/lineCar.sv */
`timescale 1ns/10ps
`default_nettype none

module lineCar (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            run,
    input  wire navPkg::roadCode road,
    output panelPkg::ledWord     led,
    output panelPkg::digitWord   digits
);

    navPkg::navState state;
    navPkg::navState lastState;

    logic       countFinish;
    logic [1:0] countStep;
    logic       countFlash;
    logic       reStart;
    logic       backFlash;

    routeIf route ();

    phaseTimers uTimers (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .countFinish (countFinish),
        .countStep   (countStep),
        .countFlash  (countFlash),
        .reStart     (reStart),
        .backFlash   (backFlash)
    );

    checkpointTracker uTracker (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .lastState (lastState),
        .road      (road),
        .route     (route.tracker)
    );

    navFsm uFsm (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .road        (road),
        .countFinish (countFinish),
        .reStart     (reStart),
        .route       (route.fsm),
        .state       (state),
        .lastState   (lastState)
    );

    statusPanel uPanel (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .road       (road),
        .countStep  (countStep),
        .countFlash (countFlash),
        .backFlash  (backFlash),
        .route      (route.panel),
        .led        (led),
        .digits     (digits)
    );

endmodule

`default_nettype wire

/* logic/navFsm.sv */
`timescale 1ns/10ps
`default_nettype none

module navFsm (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            run,
    input  wire navPkg::roadCode road,
    input  wire logic            countFinish,
    input  wire logic            reStart,
    routeIf.fsm                  route,
    output navPkg::navState      state,
    output navPkg::navState      lastState
);

    navPkg::navState nextState;

    // Run switch low drops to IDLE at the edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= navPkg::IDLE;
            lastState <= navPkg::IDLE;
        end else begin
            lastState <= state;
            if (!run) begin
                state <= navPkg::IDLE;
            end else begin
                state <= nextState;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            navPkg::IDLE: begin
                if (run) begin
                    nextState = navPkg::START;
                end
            end
            navPkg::START: begin
                if (road == navPkg::roadMid) begin
                    nextState = navPkg::COUNT;
                end
            end
            navPkg::COUNT: begin
                if (countFinish) begin
                    nextState = navPkg::STRAIGHT;
                end
            end
            navPkg::STRAIGHT, navPkg::LITTLE_LEFT, navPkg::LITTLE_RIGHT: begin
                case (road)
                    navPkg::roadNone:
                        nextState = navPkg::STOP;
                    navPkg::roadFull:
                        nextState = route.cp2 ? navPkg::CHOOSE : navPkg::STRAIGHT;
                    navPkg::roadRight, navPkg::roadLittleRight:
                        nextState = navPkg::LITTLE_RIGHT;
                    navPkg::roadLeft, navPkg::roadLittleLeft:
                        nextState = navPkg::LITTLE_LEFT;
                    default:
                        nextState = navPkg::STRAIGHT;
                endcase
            end
            navPkg::CHOOSE: begin
                if (road == navPkg::roadSplit) begin
                    nextState = navPkg::STOP;
                end else if (road == navPkg::roadFull && route.cp1) begin
                    nextState = navPkg::STRAIGHT;
                end
            end
            navPkg::LEFT: begin
                if ((road == navPkg::roadSplit && route.cp5) ||
                    (road == navPkg::roadFull && route.cp3)) begin
                    nextState = navPkg::STOP;
                end
            end
            navPkg::RIGHT: begin
                if (road == navPkg::roadFull && route.cp4 && route.doneRight) begin
                    nextState = navPkg::STOP;
                end else if (road == navPkg::roadSplit && route.doneRight) begin
                    nextState = navPkg::ERROR;
                end
            end
            navPkg::BACK: begin
                if (road == navPkg::roadFull) begin
                    nextState = navPkg::STOP;
                end
            end
            // Resume with the remembered manoeuvre
            navPkg::STOP: begin
                if (reStart) begin
                    nextState = route.nextManoeuvre;
                end
            end
            default: begin
                nextState = state;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/navPkg.sv */
`default_nettype none

package navPkg;

    // Left, middle, right sensor; 1 means line seen
    typedef logic [2:0] roadCode;

    typedef enum logic [4:0] {
        IDLE         = 5'd0,
        START        = 5'd1,
        COUNT        = 5'd2,
        STRAIGHT     = 5'd3,
        CHOOSE       = 5'd4,
        LEFT         = 5'd5,
        RIGHT        = 5'd6,
        BACK         = 5'd7,
        LITTLE_LEFT  = 5'd8,
        LITTLE_RIGHT = 5'd9,
        STOP         = 5'd30,
        ERROR        = 5'd31
    } navState;

    localparam roadCode roadNone        = 3'b000;
    localparam roadCode roadLittleRight = 3'b001;
    localparam roadCode roadMid         = 3'b010;
    localparam roadCode roadRight       = 3'b011;
    localparam roadCode roadLittleLeft  = 3'b100;
    localparam roadCode roadSplit       = 3'b101;
    localparam roadCode roadLeft        = 3'b110;
    localparam roadCode roadFull        = 3'b111;

    // Straight running including the small corrections
    function automatic logic isStraight(navState s);
        return (s == STRAIGHT) || (s == LITTLE_LEFT) || (s == LITTLE_RIGHT);
    endfunction

endpackage

`default_nettype wire

/* logic/panelPkg.sv */
`default_nettype none

package panelPkg;

    // One seven-segment symbol, 10 to 15 are A, dash, C, D, E, F
    typedef logic [3:0] digitCode;

    // Four symbols, digit 0 in the top nibble
    typedef logic [15:0] digitWord;

    typedef logic [15:0] ledWord;

    localparam digitCode digitA    = 4'd10;
    localparam digitCode digitDash = 4'd11;
    localparam digitCode digitC    = 4'd12;
    localparam digitCode digitD    = 4'd13;
    localparam digitCode digitE    = 4'd14;
    localparam digitCode digitF    = 4'd15;

endpackage

`default_nettype wire

/* logic/phaseTimers.sv */
`timescale 1ns/10ps
`default_nettype none

`include "car_consts.svh"

module phaseTimers (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire navPkg::navState state,
    output logic                 countFinish,
    output logic [1:0]           countStep,
    output logic                 countFlash,
    output logic                 reStart,
    output logic                 backFlash
);

    localparam int StepW  = $clog2(`COUNT_STEP_TICKS + 1);
    localparam int HoldW  = $clog2(`STOP_HOLD_TICKS + 1);
    localparam int FlashW = $clog2(`BACK_FLASH_TICKS + 1);

    localparam logic [StepW-1:0]  StepLoad  = StepW'(`COUNT_STEP_TICKS - 1);
    localparam logic [HoldW-1:0]  HoldLoad  = HoldW'(`STOP_HOLD_TICKS - 1);
    localparam logic [FlashW-1:0] FlashLoad = FlashW'(`BACK_FLASH_TICKS - 1);

    logic [StepW-1:0]  stepCnt;
    logic [HoldW-1:0]  holdCnt;
    logic [FlashW-1:0] flashCnt;

    logic inCount;
    logic inStop;
    logic inBack;

    assign inCount = (state == navPkg::COUNT);
    assign inStop  = (state == navPkg::STOP);
    assign inBack  = (state == navPkg::BACK);

    // Countdown, four steps of COUNT_STEP_TICKS each
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stepCnt    <= StepLoad;
            countStep  <= 2'd0;
            countFlash <= 1'b0;
        end else if (!inCount) begin
            stepCnt    <= StepLoad;
            countStep  <= 2'd0;
            countFlash <= 1'b0;
        end else if (stepCnt == '0) begin
            stepCnt    <= StepLoad;
            countStep  <= countStep + 2'd1;
            countFlash <= ~countFlash;
        end else begin
            stepCnt <= stepCnt - 1'b1;
        end
    end

    // Last cycle of the last step
    assign countFinish = inCount && (countStep == 2'd3) && (stepCnt == '0);

    // Stop hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            holdCnt <= HoldLoad;
        end else if (!inStop) begin
            holdCnt <= HoldLoad;
        end else if (holdCnt != '0) begin
            holdCnt <= holdCnt - 1'b1;
        end
    end

    assign reStart = inStop && (holdCnt == '0);

    // Reverse flash
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flashCnt  <= FlashLoad;
            backFlash <= 1'b0;
        end else if (!inBack) begin
            flashCnt  <= FlashLoad;
            backFlash <= 1'b0;
        end else if (flashCnt == '0) begin
            flashCnt  <= FlashLoad;
            backFlash <= ~backFlash;
        end else begin
            flashCnt <= flashCnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/routeIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface routeIf;

    // Checkpoints of the current phase
    logic cp1;
    logic cp2;
    logic cp3;
    logic cp4;
    logic cp5;

    // Right-turn progress
    logic doneRight;
    logic [1:0] rightCount;

    // State taken when STOP ends
    navPkg::navState nextManoeuvre;

    modport tracker (
        output cp1, cp2, cp3, cp4, cp5, doneRight, rightCount, nextManoeuvre
    );

    modport fsm (
        input cp1, cp2, cp3, cp4, cp5, doneRight, nextManoeuvre
    );

    modport panel (
        input cp1, cp2, cp3, cp4, rightCount, nextManoeuvre
    );

endinterface

`default_nettype wire

/* logic/statusPanel.sv */
`timescale 1ns/10ps
`default_nettype none

`include "car_consts.svh"

module statusPanel (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire navPkg::navState state,
    input  wire navPkg::roadCode road,
    input  wire logic [1:0]      countStep,
    input  wire logic            countFlash,
    input  wire logic            backFlash,
    routeIf.panel                route,
    output panelPkg::ledWord     led,
    output panelPkg::digitWord   digits
);

    localparam int LampW = $clog2(`LAMP_TICKS + 1);
    localparam logic [LampW-1:0] LampLast = LampW'(`LAMP_TICKS - 1);

    logic [LampW-1:0] lampCnt;
    logic [2:0] lamp;
    logic [4:0] phaseBits;
    logic [5:0] barBits;
    logic [1:0] remaining;
    panelPkg::digitCode d0, d1, d2, d3;
    panelPkg::digitCode routeCode;

    // Rotating lamp, only runs in CHOOSE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCnt <= '0;
            lamp    <= 3'b001;
        end else if (state != navPkg::CHOOSE) begin
            lampCnt <= '0;
            lamp    <= 3'b001;
        end else if (lampCnt == LampLast) begin
            lampCnt <= '0;
            lamp    <= {lamp[1:0], lamp[2]};
        end else begin
            lampCnt <= lampCnt + 1'b1;
        end
    end

    always_comb begin
        case (route.nextManoeuvre)
            navPkg::STRAIGHT: routeCode = 4'd1;
            navPkg::LEFT:     routeCode = panelPkg::digitD;
            navPkg::RIGHT:    routeCode = panelPkg::digitF;
            navPkg::BACK:     routeCode = panelPkg::digitDash;
            default:          routeCode = 4'd0;
        endcase
    end

    assign remaining = 2'd3 - countStep;

    always_comb begin
        phaseBits = 5'b00000;
        barBits   = 6'b000000;
        d0 = 4'd0;
        d1 = 4'd0;
        d2 = 4'd0;
        d3 = 4'd0;
        case (state)
            navPkg::IDLE: begin
                d0 = 4'd1;
                d1 = panelPkg::digitC;
                d2 = panelPkg::digitD;
                d3 = panelPkg::digitE;
            end
            navPkg::START: begin
                phaseBits = 5'b00001;
                d0 = panelPkg::digitDash;
                d1 = panelPkg::digitDash;
                d2 = panelPkg::digitDash;
                d3 = panelPkg::digitDash;
            end
            navPkg::COUNT: begin
                phaseBits = 5'b00010;
                barBits   = countFlash ? 6'b000000 : 6'b111111;
                d0 = panelPkg::digitDash;
                d1 = panelPkg::digitDash;
                d2 = panelPkg::digitDash;
                d3 = {2'b00, remaining};
            end
            navPkg::STRAIGHT, navPkg::LITTLE_LEFT, navPkg::LITTLE_RIGHT: begin
                phaseBits = 5'b01000;
                barBits   = 6'b001100;
                d0 = panelPkg::digitA;
                d1 = 4'd2;
                d2 = panelPkg::digitDash;
                d3 = {3'b000, route.cp2};
            end
            navPkg::CHOOSE: begin
                phaseBits = {lamp, 2'b00};
                d0 = panelPkg::digitA;
                d1 = 4'd1;
                d2 = panelPkg::digitDash;
                d3 = {3'b000, route.cp1};
            end
            navPkg::LEFT: begin
                phaseBits = 5'b10000;
                barBits   = 6'b110000;
                d0 = panelPkg::digitA;
                d1 = 4'd3;
                d2 = panelPkg::digitDash;
                d3 = {3'b000, route.cp3};
            end
            navPkg::RIGHT: begin
                phaseBits = 5'b00100;
                barBits   = 6'b000011;
                d0 = 4'd4;
                d1 = {3'b000, route.cp4};
                d2 = panelPkg::digitDash;
                d3 = {2'b00, route.rightCount};
            end
            navPkg::BACK: begin
                phaseBits = 5'b01010;
                barBits   = backFlash ? 6'b000000 : 6'b111111;
                d0 = panelPkg::digitDash;
                d3 = routeCode;
            end
            navPkg::STOP: begin
                phaseBits = 5'b11100;
                barBits   = 6'b111111;
                d3 = routeCode;
            end
            navPkg::ERROR: begin
                phaseBits = 5'b11111;
            end
            default: begin
            end
        endcase
    end

    // Phase, gap, motion bar, gap, sensors
    assign led    = {phaseBits, 1'b0, barBits, 1'b0, road};
    assign digits = {d0, d1, d2, d3};

endmodule

`default_nettype wire

/* sim/lineCar_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module lineCar_asserts (
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            run,
    input wire logic            reStart,
    input wire navPkg::navState state
);

    // Raised by any failing assertion
    logic failSeen = 1'b0;

    // Run switch low clears to IDLE
    runLowIdle: assert property (@(posedge clk) disable iff (rst)
        !run |=> state == navPkg::IDLE)
        else begin
            $error("run low did not give IDLE");
            failSeen = 1'b1;
        end

    // STOP holds until the hold timer fires
    stopHold: assert property (@(posedge clk) disable iff (rst)
        (state == navPkg::STOP && run && !reStart) |=> state == navPkg::STOP)
        else begin
            $error("STOP left without reStart");
            failSeen = 1'b1;
        end

    errorHold: assert property (@(posedge clk) disable iff (rst)
        (state == navPkg::ERROR && run) |=> state == navPkg::ERROR)
        else begin
            $error("ERROR left while run high");
            failSeen = 1'b1;
        end

endmodule

bind navFsm lineCar_asserts uAsserts (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .reStart (reStart),
    .state   (state)
);

`default_nettype wire

/* sim/lineCar_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "car_consts.svh"

module lineCar_tb;

    // One table row: stimulus, hold length and the display after the hold
    typedef struct packed {
        logic               run;
        navPkg::roadCode    road;
        logic [7:0]         hold;
        logic               rnd;
        panelPkg::digitWord digits;
        logic [4:0]         phase;
        logic [5:0]         bar;
    } stepRow;

    logic               clk;
    logic               rst;
    logic               run;
    navPkg::roadCode    road;
    panelPkg::ledWord   led;
    panelPkg::digitWord digits;

    stepRow rows[$];
    integer seed;
    int     limitCycles;

    lineCar u_dut (
        .clk    (clk),
        .rst    (rst),
        .run    (run),
        .road   (road),
        .led    (led),
        .digits (digits)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic addRow(input logic r, input navPkg::roadCode c, input int h,
                          input logic rnd, input panelPkg::digitWord d,
                          input logic [4:0] p, input logic [5:0] b);
        stepRow e;
        e = {r, c, 8'(h), rnd, d, p, b};
        rows.push_back(e);
    endtask

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkDigits(input panelPkg::digitWord got, input panelPkg::digitWord exp,
                               input int row);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0d ns: row %0d digits %h, expected %h",
                              $time, row, got, exp));
        end
    endtask

    task automatic checkLed(input panelPkg::ledWord got, input panelPkg::ledWord exp,
                            input int row);
        if (got !== exp) begin
            failRun($sformatf("Mismatch at %0d ns: row %0d led %b, expected %b",
                              $time, row, got, exp));
        end
    endtask

    // COUNT and STOP ignore the road, so any code keeps the state
    function automatic navPkg::roadCode randomRoad();
        return navPkg::roadCode'($random(seed));
    endfunction

    task automatic buildTable();
        // Idle, start and countdown
        addRow(0, 3'b000, 2, 0, 16'h1CDE, 5'b00000, 6'b000000);
        addRow(1, 3'b000, 1, 0, 16'hBBBB, 5'b00001, 6'b000000);
        addRow(1, 3'b010, 1, 0, 16'hBBB3, 5'b00010, 6'b111111);
        addRow(1, 3'b000, `COUNT_STEP_TICKS, 1, 16'hBBB2, 5'b00010, 6'b000000);
        addRow(1, 3'b000, `COUNT_STEP_TICKS, 1, 16'hBBB1, 5'b00010, 6'b111111);
        addRow(1, 3'b000, `COUNT_STEP_TICKS, 1, 16'hBBB0, 5'b00010, 6'b000000);
        addRow(1, 3'b000, `COUNT_STEP_TICKS - 1, 1, 16'hBBB0, 5'b00010, 6'b000000);
        addRow(1, 3'b010, 1, 0, 16'hA2B1, 5'b01000, 6'b001100);
        // Small corrections
        addRow(1, 3'b011, 1, 0, 16'hA2B1, 5'b01000, 6'b001100);
        addRow(1, 3'b110, 1, 0, 16'hA2B1, 5'b01000, 6'b001100);
        addRow(1, 3'b010, 1, 0, 16'hA2B1, 5'b01000, 6'b001100);
        // Junction, lamp rotation, then left choice
        addRow(1, 3'b111, 1, 0, 16'hA1B0, 5'b00100, 6'b000000);
        addRow(1, 3'b111, `LAMP_TICKS, 0, 16'hA1B0, 5'b01000, 6'b000000);
        addRow(1, 3'b111, `LAMP_TICKS, 0, 16'hA1B0, 5'b10000, 6'b000000);
        addRow(1, 3'b111, `LAMP_TICKS, 0, 16'hA1B0, 5'b00100, 6'b000000);
        addRow(1, 3'b101, 1, 0, 16'h000D, 5'b11100, 6'b111111);
        addRow(1, 3'b000, `STOP_HOLD_TICKS - 1, 1, 16'h000D, 5'b11100, 6'b111111);
        addRow(1, 3'b010, 1, 0, 16'hA3B0, 5'b10000, 6'b110000);
        // Left turn ends on the full line, back to straight
        addRow(1, 3'b010, 1, 0, 16'hA3B1, 5'b10000, 6'b110000);
        addRow(1, 3'b111, 1, 0, 16'h0001, 5'b11100, 6'b111111);
        addRow(1, 3'b000, `STOP_HOLD_TICKS - 1, 1, 16'h0001, 5'b11100, 6'b111111);
        addRow(1, 3'b010, 1, 0, 16'hA2B0, 5'b01000, 6'b001100);
        addRow(1, 3'b010, 1, 0, 16'hA2B1, 5'b01000, 6'b001100);
        // Line lost, reverse search with flashing bar
        addRow(1, 3'b000, 1, 0, 16'h000B, 5'b11100, 6'b111111);
        addRow(1, 3'b000, `STOP_HOLD_TICKS - 1, 1, 16'h000B, 5'b11100, 6'b111111);
        addRow(1, 3'b000, 1, 0, 16'hB00B, 5'b01010, 6'b111111);
        addRow(1, 3'b000, `BACK_FLASH_TICKS, 0, 16'hB00B, 5'b01010, 6'b000000);
        addRow(1, 3'b000, `BACK_FLASH_TICKS, 0, 16'hB00B, 5'b01010, 6'b111111);
        addRow(1, 3'b111, 1, 0, 16'h000D, 5'b11100, 6'b111111);
        addRow(1, 3'b000, `STOP_HOLD_TICKS - 1, 1, 16'h000D, 5'b11100, 6'b111111);
        addRow(1, 3'b010, 1, 0, 16'hA3B0, 5'b10000, 6'b110000);
        // Left turn sees the split, right turn comes next
        addRow(1, 3'b010, 1, 0, 16'hA3B1, 5'b10000, 6'b110000);
        addRow(1, 3'b101, 1, 0, 16'h000F, 5'b11100, 6'b111111);
        addRow(1, 3'b000, `STOP_HOLD_TICKS - 1, 1, 16'h000F, 5'b11100, 6'b111111);
        addRow(1, 3'b010, 1, 0, 16'h40B0, 5'b00100, 6'b000011);
        addRow(1, 3'b010, 1, 0, 16'h41B0, 5'b00100, 6'b000011);
        // Two full-line edges, then the split is an error
        addRow(1, 3'b111, 1, 0, 16'h41B1, 5'b00100, 6'b000011);
        addRow(1, 3'b010, 1, 0, 16'h41B1, 5'b00100, 6'b000011);
        addRow(1, 3'b111, 1, 0, 16'h41B2, 5'b00100, 6'b000011);
        addRow(1, 3'b010, 1, 0, 16'h41B2, 5'b00100, 6'b000011);
        addRow(1, 3'b101, 1, 0, 16'h0000, 5'b11111, 6'b000000);
        addRow(1, 3'b101, 5, 0, 16'h0000, 5'b11111, 6'b000000);
        addRow(0, 3'b000, 1, 0, 16'h1CDE, 5'b00000, 6'b000000);
    endtask

    // Watchdog sized from the table
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        failRun("Timeout: the table did not finish in the expected number of cycles");
    end

    // A failing state machine assertion ends the run
    initial begin
        wait (u_dut.uFsm.uAsserts.failSeen);
        failRun("An assertion on the state machine failed");
    end

    initial begin
        stepRow cur;
        int     total;
        seed        = 43948;
        limitCycles = 0;
        rst         = 1'b1;
        run         = 1'b0;
        road        = 3'b000;

        buildTable();
        total = 0;
        foreach (rows[i]) begin
            total += rows[i].hold;
        end
        limitCycles = total + 4 + 20;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            cur  = rows[i];
            run  = cur.run;
            road = cur.rnd ? randomRoad() : cur.road;
            for (int k = 0; k < cur.hold; k++) begin
                @(posedge clk);
                @(negedge clk);
                if (cur.rnd && k != cur.hold - 1) begin
                    road = randomRoad();
                end
            end
            checkDigits(digits, cur.digits, i);
            checkLed(led, {cur.phase, 1'b0, cur.bar, 1'b0, road}, i);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/navPkg.sv
logic/panelPkg.sv
logic/routeIf.sv
logic/phaseTimers.sv
logic/checkpointTracker.sv
logic/navFsm.sv
logic/statusPanel.sv
logic/lineCar.sv
sim/lineCar_asserts.sv
sim/lineCar_tb.sv
